// ==== chan_pkg.sv ====
package chan_pkg;

	////////////////////
	// sample and word sizes
	localparam int SAMPLE_W = 12;                // one adc sample
	localparam int LANE_W = 16;                  // lane holding one sample
	localparam int LANES = 8;                    // samples per burst
	localparam int LANE_CNT_W = $clog2(LANES);
	localparam int WORD_W = 128;                 // burst or header word
	localparam int CNT_W = 24;                   // burst counts and fill numbers

	////////////////////
	// storage sizes
	localparam int ADDR_W = 10;
	localparam int RAM_DEPTH = 1024;             // addresses wrap at this depth
	localparam int FIFO_DEPTH = 16;
	localparam int FIFO_AW = $clog2(FIFO_DEPTH);

	// tag bits on each write word
	localparam int TAG_W = 4;
	localparam int TAG_HDR = 0;                  // word is a fill header
	localparam int TAG_LAST = 1;                 // final word of a fill

	// encoded straight from {acq_enable1, acq_enable0}
	typedef enum logic [1:0] {NONE = 2'b00, MUON = 2'b01, LASER = 2'b10, PED = 2'b11} fill_type_t;

	typedef struct packed {
		logic [15:0] channel_tag;
		logic [7:0] fill_type;                   // fill_type_t zero-extended
		logic [CNT_W-1:0] fill_num;
		logic [CNT_W-1:0] burst_count;
		logic [CNT_W-1:0] start_addr;            // memory address zero-extended
		logic [31:0] reserved;
	} fill_hdr_t;

	typedef struct packed {
		logic [TAG_W-1:0] tag;
		logic [WORD_W-1:0] data;
	} wr_word_t;

endpackage

// ==== chan_if.sv ====
`timescale 1ns/10ps

////////////////////
// fill command from decode to sequencer
interface fill_cmd_if import chan_pkg::*; ();
	logic start;                       // one cycle, only while busy is low
	fill_type_t fill_type;
	logic [CNT_W-1:0] burst_count;
	logic [CNT_W-1:0] fill_num;
	logic busy;                        // sequencer is packing a fill

	modport decode (output start, fill_type, burst_count, fill_num, input busy);
	modport seq (input start, fill_type, burst_count, fill_num, output busy);
endinterface

////////////////////
// burst memory port
interface burst_mem_if import chan_pkg::*; ();
	logic wr_en;
	logic [ADDR_W-1:0] wr_addr;
	logic [WORD_W-1:0] wr_dat;
	logic rd_en;
	logic [ADDR_W-1:0] rd_addr;
	logic [WORD_W-1:0] rd_dat;         // one cycle after rd_en
	logic rd_vld;

	modport store (output wr_en, wr_addr, wr_dat, rd_en, rd_addr, input rd_dat, rd_vld);
	modport ram (input wr_en, wr_addr, wr_dat, rd_en, rd_addr, output rd_dat, rd_vld);
endinterface

// ==== fill_decode.sv ====
`timescale 1ns/10ps

module fill_decode import chan_pkg::*; (
	input logic clk125,
	input logic reset,
	input logic acq_enable0,                       // enable level, low bit of fill type
	input logic acq_enable1,                       // enable level, high bit of fill type
	input logic acq_trig,                          // start a fill
	input logic initial_fill_num_wr,               // load strobe for the fill counter
	input logic [CNT_W-1:0] initial_fill_num,
	input logic [CNT_W-1:0] num_muon_bursts,
	input logic [CNT_W-1:0] num_laser_bursts,
	input logic [CNT_W-1:0] num_ped_bursts,
	output logic acq_enabled,                      // any fill type selected
	output logic [CNT_W-1:0] fill_num,             // number the next fill will get
	fill_cmd_if.decode cmd
);

	fill_type_t type_dec;
	logic [CNT_W-1:0] count_dec;
	logic [CNT_W-1:0] fill_cnt;
	logic accept;

	assign acq_enabled = acq_enable0 | acq_enable1;
	assign type_dec = fill_type_t'({acq_enable1, acq_enable0});
	assign fill_num = fill_cnt;

	always_comb begin
		case (type_dec)
			MUON: count_dec = num_muon_bursts;
			LASER: count_dec = num_laser_bursts;
			PED: count_dec = num_ped_bursts;
			default: count_dec = '0;               // NONE never gets accepted
		endcase
	end

	// start still high counts as busy, the sequencer has not seen it yet
	assign accept = acq_trig & acq_enabled & ~cmd.busy & ~cmd.start;

	always_ff @(posedge clk125) begin
		if (reset) begin
			cmd.start <= 1'b0;
			fill_cnt <= '0;
		end else begin
			cmd.start <= accept;                   // single cycle pulse
			if (initial_fill_num_wr)
				fill_cnt <= initial_fill_num;
			else if (accept)
				fill_cnt <= fill_cnt + 1'b1;       // next fill number
		end
	end

	// command fields held with the pulse
	always_ff @(posedge clk125) begin
		if (accept) begin
			cmd.fill_type <= type_dec;
			cmd.burst_count <= count_dec;
			cmd.fill_num <= fill_cnt;
		end
	end

endmodule

// ==== acq_sequencer.sv ====
`timescale 1ns/10ps

module acq_sequencer import chan_pkg::*; (
	input logic clk125,
	input logic reset,
	input logic [15:0] channel_tag,                // goes into every header
	input logic [SAMPLE_W-1:0] adc_sample,         // fresh every cycle
	fill_cmd_if.seq cmd,
	output logic push,                             // write FIFO strobe
	output wr_word_t push_word                     // tag plus header or burst
);

	typedef enum logic {IDLE, PACK} seq_state_t;

	seq_state_t state;
	logic [WORD_W-1:0] lanes;                      // shift register of samples
	logic [WORD_W-1:0] lanes_nxt;
	logic [LANE_CNT_W-1:0] lane_cnt;               // samples in the current burst
	logic [CNT_W-1:0] bursts_left;
	logic burst_done;
	fill_hdr_t hdr;

	assign cmd.busy = (state == PACK);

	// new sample enters the top lane, the oldest ends up in lane 0
	assign lanes_nxt = {LANE_W'(adc_sample), lanes[WORD_W-1:LANE_W]};
	assign burst_done = (state == PACK) && (lane_cnt == LANE_CNT_W'(LANES - 1));

	always_comb begin
		hdr.channel_tag = channel_tag;
		hdr.fill_type = 8'(cmd.fill_type);
		hdr.fill_num = cmd.fill_num;
		hdr.burst_count = cmd.burst_count;
		hdr.start_addr = '0;                       // stamped later by the store
		hdr.reserved = '0;
	end

	////////////////////
	// fsm
	always_ff @(posedge clk125) begin
		if (reset) begin
			state <= IDLE;
			push <= 1'b0;
			lane_cnt <= '0;
			bursts_left <= '0;
		end else begin
			push <= 1'b0;
			case (state)
				IDLE: begin
					if (cmd.start) begin
						push <= 1'b1;              // header word
						lane_cnt <= LANE_CNT_W'(1);   // first sample taken on this edge
						bursts_left <= cmd.burst_count;
						if (cmd.burst_count != '0)
							state <= PACK;
					end
				end
				PACK: begin
					lane_cnt <= lane_cnt + 1'b1;   // wraps every burst
					if (burst_done) begin
						push <= 1'b1;
						bursts_left <= bursts_left - 1'b1;
						if (bursts_left == CNT_W'(1))
							state <= IDLE;         // last burst pushed
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	////////////////////
	// sample and word registers
	always_ff @(posedge clk125) begin
		lanes <= lanes_nxt;
		if (state == IDLE && cmd.start) begin
			push_word.tag <= '0;
			push_word.tag[TAG_HDR] <= 1'b1;
			push_word.tag[TAG_LAST] <= (cmd.burst_count == '0);   // empty fill
			push_word.data <= hdr;
		end else if (burst_done) begin
			push_word.tag <= '0;
			push_word.tag[TAG_LAST] <= (bursts_left == CNT_W'(1));
			push_word.data <= lanes_nxt;           // includes the 8th sample
		end
	end

endmodule

// ==== sync_fifo.sv ====
`timescale 1ns/10ps

module sync_fifo import chan_pkg::*; #(
	parameter type payload_t = logic [WORD_W-1:0]
) (
	input logic clk125,
	input logic reset,
	input logic push,
	input logic pop,
	input payload_t din,
	output payload_t dout,                         // head word, valid while not empty
	output logic empty,
	output logic full
);

	payload_t buf_mem [FIFO_DEPTH];
	logic [FIFO_AW-1:0] wr_ptr;
	logic [FIFO_AW-1:0] rd_ptr;
	logic [FIFO_AW:0] count;                       // one extra bit for full
	logic do_push;
	logic do_pop;

	assign do_push = push & ~full;                 // dropped when full
	assign do_pop = pop & ~empty;                  // ignored when empty
	assign empty = (count == '0);
	assign full = (count == (FIFO_AW + 1)'(FIFO_DEPTH));
	assign dout = buf_mem[rd_ptr];                 // show-ahead

	always_ff @(posedge clk125) begin
		if (do_push)
			buf_mem[wr_ptr] <= din;
	end

	always_ff @(posedge clk125) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;           // wraps at FIFO_DEPTH
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;           // both or neither
			endcase
		end
	end

endmodule

// ==== burst_ram.sv ====
`timescale 1ns/10ps

module burst_ram import chan_pkg::*; (
	input logic clk125,
	burst_mem_if.ram mem
);

	logic [WORD_W-1:0] ram [RAM_DEPTH];

	// write port
	always_ff @(posedge clk125) begin
		if (mem.wr_en)
			ram[mem.wr_addr] <= mem.wr_dat;
	end

	// registered read, one cycle latency
	always_ff @(posedge clk125) begin
		if (mem.rd_en)
			mem.rd_dat <= ram[mem.rd_addr];
		mem.rd_vld <= mem.rd_en;                   // follows rd_en by one cycle
	end

endmodule

// ==== burst_store.sv ====
`timescale 1ns/10ps

module burst_store import chan_pkg::*; (
	input logic clk125,
	input logic reset,
	input wr_word_t fifo_dout,                     // head of the write FIFO
	input logic fifo_empty,
	output logic fifo_pop,
	input logic [ADDR_W-1:0] fixed_start_addr,
	input logic en_fixed_start_addr,               // use fixed_start_addr for this fill
	output logic hdr_push,                         // to the header FIFO
	output fill_hdr_t hdr_word,
	output logic acq_done,                         // last word of a fill written
	input logic [ADDR_W-1:0] rd_start_addr,
	input logic [CNT_W-1:0] rd_burst_cnt,
	input logic enable_reading,                    // load address and count, go
	input logic rd_fifo_almost_full,               // pause reads while high
	output logic [WORD_W-1:0] rd_dat,
	output logic rd_valid,
	output logic rd_last,
	output logic reading_done,
	burst_mem_if.store mem
);

	logic [ADDR_W-1:0] wr_ptr;                     // address after the last word written
	logic [ADDR_W-1:0] start_addr;
	logic [ADDR_W-1:0] word_addr;
	logic is_hdr;
	logic [ADDR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] rd_left;                     // words still to be read
	logic rd_issue;
	logic last_pend;                               // lines up with the ram latency

	////////////////////
	// write side
	assign fifo_pop = ~fifo_empty;                 // drain every cycle
	assign is_hdr = fifo_dout.tag[TAG_HDR];
	assign start_addr = en_fixed_start_addr ? fixed_start_addr : wr_ptr;
	assign word_addr = is_hdr ? start_addr : wr_ptr;

	always_comb begin
		hdr_word = fill_hdr_t'(fifo_dout.data);
		hdr_word.start_addr = CNT_W'(start_addr);  // stamp where the fill begins
	end

	assign hdr_push = fifo_pop & is_hdr;
	assign mem.wr_en = fifo_pop;
	assign mem.wr_addr = word_addr;
	assign mem.wr_dat = is_hdr ? WORD_W'(hdr_word) : fifo_dout.data;

	always_ff @(posedge clk125) begin
		if (reset) begin
			wr_ptr <= '0;
			acq_done <= 1'b0;
		end else begin
			acq_done <= fifo_pop & fifo_dout.tag[TAG_LAST];
			if (fifo_pop)
				wr_ptr <= word_addr + 1'b1;        // wraps at RAM_DEPTH
		end
	end

	////////////////////
	// read side
	assign rd_issue = (rd_left != '0) & ~rd_fifo_almost_full;
	assign mem.rd_en = rd_issue;
	assign mem.rd_addr = rd_ptr;
	assign rd_dat = mem.rd_dat;
	assign rd_valid = mem.rd_vld;
	assign rd_last = last_pend;
	assign reading_done = last_pend;

	always_ff @(posedge clk125) begin
		if (reset) begin
			rd_ptr <= '0;
			rd_left <= '0;
			last_pend <= 1'b0;
		end else begin
			last_pend <= rd_issue & (rd_left == CNT_W'(1));   // final read issued
			if (enable_reading) begin
				rd_ptr <= rd_start_addr;
				rd_left <= rd_burst_cnt;
			end else if (rd_issue) begin
				rd_ptr <= rd_ptr + 1'b1;
				rd_left <= rd_left - 1'b1;
			end
		end
	end

endmodule

// ==== chan_top.sv ====
`timescale 1ns/10ps

module chan_top import chan_pkg::*; (
	input logic clk125,
	input logic reset,
	input logic [15:0] channel_tag,
	input logic [SAMPLE_W-1:0] adc_sample,
	input logic acq_enable0,
	input logic acq_enable1,
	input logic acq_trig,
	input logic initial_fill_num_wr,
	input logic [CNT_W-1:0] initial_fill_num,
	input logic [CNT_W-1:0] num_muon_bursts,
	input logic [CNT_W-1:0] num_laser_bursts,
	input logic [CNT_W-1:0] num_ped_bursts,
	input logic [ADDR_W-1:0] fixed_start_addr,
	input logic en_fixed_start_addr,
	output logic acq_enabled,
	output logic [CNT_W-1:0] fill_num,
	output logic acq_done,
	input logic fill_header_fifo_rd_en,            // pop the header at the head
	output logic fill_header_fifo_empty,
	output logic [WORD_W-1:0] fill_header_fifo_out,
	input logic [ADDR_W-1:0] rd_start_addr,
	input logic [CNT_W-1:0] rd_burst_cnt,
	input logic enable_reading,
	input logic rd_fifo_almost_full,
	output logic [WORD_W-1:0] rd_dat,
	output logic rd_valid,
	output logic rd_last,
	output logic reading_done
);

	logic wr_push;
	wr_word_t wr_din;
	wr_word_t wr_dout;
	logic wr_pop;
	logic wr_empty;
	logic wr_full;                                 // watched by the assertions
	logic hdr_push;
	fill_hdr_t hdr_din;

	fill_cmd_if u_cmd_if ();
	burst_mem_if u_mem_if ();

	////////////////////
	// decode and execute
	fill_decode u_fill_decode (
		.clk125, .reset, .acq_enable0, .acq_enable1, .acq_trig,
		.initial_fill_num_wr, .initial_fill_num,
		.num_muon_bursts, .num_laser_bursts, .num_ped_bursts,
		.acq_enabled, .fill_num, .cmd(u_cmd_if.decode)
	);

	acq_sequencer u_acq_sequencer (
		.clk125, .reset, .channel_tag, .adc_sample,
		.cmd(u_cmd_if.seq), .push(wr_push), .push_word(wr_din)
	);

	sync_fifo #(.payload_t(wr_word_t)) u_wr_fifo (
		.clk125, .reset, .push(wr_push), .pop(wr_pop), .din(wr_din),
		.dout(wr_dout), .empty(wr_empty), .full(wr_full)
	);

	////////////////////
	// result store and readout
	burst_store u_burst_store (
		.clk125, .reset, .fifo_dout(wr_dout), .fifo_empty(wr_empty), .fifo_pop(wr_pop),
		.fixed_start_addr, .en_fixed_start_addr, .hdr_push, .hdr_word(hdr_din), .acq_done,
		.rd_start_addr, .rd_burst_cnt, .enable_reading, .rd_fifo_almost_full,
		.rd_dat, .rd_valid, .rd_last, .reading_done, .mem(u_mem_if.store)
	);

	burst_ram u_burst_ram (.clk125, .mem(u_mem_if.ram));

	sync_fifo #(.payload_t(fill_hdr_t)) u_hdr_fifo (
		.clk125, .reset, .push(hdr_push), .pop(fill_header_fifo_rd_en), .din(hdr_din),
		.dout(fill_header_fifo_out), .empty(fill_header_fifo_empty), .full()
	);

endmodule

// ==== chan_tb_sva.sv ====
`timescale 1ns/10ps

module chan_tb_sva (
	input logic clk125,
	input logic reset,
	input logic wr_push,                          // write FIFO push from the sequencer
	input logic wr_full,
	input logic start,                            // fill command pulse
	input logic busy,
	input logic rd_fifo_almost_full,
	input logic rd_valid
);

	////////////////////
	// write path
	wr_push_not_full: assert property (@(posedge clk125) disable iff (reset)
		wr_push |-> !wr_full)
		else $error("write FIFO pushed while full");

	start_not_busy: assert property (@(posedge clk125) disable iff (reset)
		start |-> !busy)
		else $error("fill start pulsed while the sequencer was busy");

	////////////////////
	// readout pacing, no read issued while almost_full so nothing arrives next cycle
	no_data_after_full: assert property (@(posedge clk125) disable iff (reset)
		rd_fifo_almost_full |=> !rd_valid)
		else $error("rd_valid high after almost_full with no read pending");

endmodule

bind chan_top chan_tb_sva u_sva (
	.clk125, .reset, .wr_push, .wr_full,
	.start(u_cmd_if.start), .busy(u_cmd_if.busy),
	.rd_fifo_almost_full, .rd_valid
);

// ==== chan_tb.sv ====
`timescale 1ns/10ps

module chan_tb import chan_pkg::*; ();

	localparam int MUON_N = 3;                    // bursts per fill type
	localparam int LASER_N = 2;
	localparam int PED_N = 4;
	localparam logic [CNT_W-1:0] INIT_NUM = 24'h000100;
	localparam logic [ADDR_W-1:0] FIXED_ADDR = 10'h200;
	localparam logic [15:0] CHAN_TAG = 16'h5a3c;
	// four fills of 8 cycles per burst plus header and drain
	localparam int FILL_CYC = 8 * (2 * MUON_N + LASER_N + PED_N) + 4 * 6;
	// two reads, paced at about half rate
	localparam int READ_CYC = 2 * (1 + MUON_N + 1 + LASER_N + 1 + PED_N + 1 + MUON_N) + 16;

	logic clk125 = 1'b0;
	logic reset;
	logic [15:0] channel_tag;
	logic [SAMPLE_W-1:0] adc_sample;
	logic acq_enable0, acq_enable1, acq_trig;
	logic initial_fill_num_wr;
	logic [CNT_W-1:0] initial_fill_num;
	logic [CNT_W-1:0] num_muon_bursts, num_laser_bursts, num_ped_bursts;
	logic [ADDR_W-1:0] fixed_start_addr;
	logic en_fixed_start_addr;
	logic acq_enabled;
	logic [CNT_W-1:0] fill_num;
	logic acq_done;
	logic fill_header_fifo_rd_en;
	logic fill_header_fifo_empty;
	logic [WORD_W-1:0] fill_header_fifo_out;
	logic [ADDR_W-1:0] rd_start_addr;
	logic [CNT_W-1:0] rd_burst_cnt;
	logic enable_reading, rd_fifo_almost_full;
	logic [WORD_W-1:0] rd_dat;
	logic rd_valid, rd_last, reading_done;

	logic [15:0] lfsr = 16'd41;                   // shared by samples and pacing
	logic [SAMPLE_W-1:0] samp_log [4096];         // sample seen at each edge
	logic [WORD_W-1:0] exp_mem [RAM_DEPTH];       // model of the burst memory
	logic [WORD_W-1:0] exp_q [$];                 // words still due on rd_dat
	logic [WORD_W-1:0] exp_hdr [$];               // headers due from the header FIFO
	logic [CNT_W-1:0] exp_num;                    // number the next fill should carry
	int edge_n = 0;
	int done_cnt = 0;
	int rd_done_cnt = 0;
	int next_addr = 0;                            // continuing start address
	logic pace_en = 1'b0;
	string cur_test = "reset";

	chan_top u_dut (.*);

	always #4 clk125 = ~clk125;                   // 125 MHz

	always @(posedge clk125)
		edge_n <= edge_n + 1;

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};   // taps 16 14 13 11
	endfunction

	// expected burst b of a fill triggered at edge k
	function automatic logic [WORD_W-1:0] burst_ref(input int k, input int b);
		logic [WORD_W-1:0] w;
		w = '0;
		for (int j = 0; j < LANES; j++)
			w[j*LANE_W +: LANE_W] = {4'b0, samp_log[k + 1 + b*LANES + j]};   // oldest in lane 0
		return w;
	endfunction

	function automatic logic [WORD_W-1:0] hdr_ref(input logic [1:0] ftype,
			input logic [CNT_W-1:0] num, input logic [CNT_W-1:0] cnt,
			input logic [ADDR_W-1:0] addr);
		return {CHAN_TAG, 6'b0, ftype, num, cnt, 14'b0, addr, 32'b0};
	endfunction

	task automatic fail_stop(input string why);
		$display("%s", why);
		$display("Simulation FAILED");
		$fatal(1);
	endtask

	task automatic check_val(input string name, input logic [WORD_W-1:0] exp_v,
			input logic [WORD_W-1:0] act_v);
		assert (act_v === exp_v)
		else fail_stop($sformatf("FAIL %s: expected %h, actual %h", name, exp_v, act_v));
	endtask

	////////////////////
	// samples and pacing, driven on the falling edge
	always @(negedge clk125) begin : drive_samples
		logic [SAMPLE_W-1:0] s;
		s = '0;
		for (int i = 0; i < SAMPLE_W; i++) begin
			lfsr = lfsr_next(lfsr);
			s = {s[SAMPLE_W-2:0], lfsr[0]};       // one step per bit
		end
		adc_sample = s;
		samp_log[edge_n] = s;                     // taken by the coming edge
		if (pace_en) begin
			lfsr = lfsr_next(lfsr);
			rd_fifo_almost_full = lfsr[0];
		end else begin
			rd_fifo_almost_full = 1'b0;
		end
	end

	////////////////////
	// compare, outputs are registered so the falling edge sees them settled
	always @(negedge clk125) begin : compare
		logic [WORD_W-1:0] exp_w;
		if (!reset) begin
			if (acq_done)
				done_cnt++;
			if (rd_valid) begin
				assert (exp_q.size() != 0)
				else fail_stop({cur_test, ": rd_valid came with no word left to read"});
				exp_w = exp_q.pop_front();
				check_val({cur_test, " rd_dat"}, exp_w, rd_dat);
				check_val({cur_test, " rd_last"}, exp_q.size() == 0, rd_last);
				check_val({cur_test, " reading_done"}, exp_q.size() == 0, reading_done);
				if (reading_done)
					rd_done_cnt++;
			end else begin
				check_val({cur_test, " rd_last idle"}, 0, rd_last);
				check_val({cur_test, " reading_done idle"}, 0, reading_done);
			end
		end
	end

	task automatic run_fill(input fill_type_t ftype, input logic fixed);
		int k;
		int n;
		int prev;
		int start;
		logic [CNT_W-1:0] num;
		n = (ftype == MUON) ? MUON_N : (ftype == LASER) ? LASER_N : PED_N;
		prev = done_cnt;
		@(negedge clk125);
		{acq_enable1, acq_enable0} = ftype;
		en_fixed_start_addr = fixed;              // held until the header is stored
		@(negedge clk125);
		check_val({cur_test, " acq_enabled"}, 1, acq_enabled);
		acq_trig = 1'b1;
		k = edge_n;                               // edge that samples the trigger
		num = exp_num;
		@(negedge clk125);
		acq_trig = 1'b0;
		wait (done_cnt == prev + 1);
		@(negedge clk125);
		check_val({cur_test, " fill_num"}, num + 1'b1, fill_num);
		exp_num = num + 1'b1;
		start = fixed ? int'(FIXED_ADDR) : next_addr;
		exp_mem[start] = hdr_ref(ftype, num, CNT_W'(n), ADDR_W'(start));
		for (int b = 0; b < n; b++)
			exp_mem[(start + 1 + b) % RAM_DEPTH] = burst_ref(k, b);
		exp_hdr.push_back(exp_mem[start]);
		next_addr = (start + 1 + n) % RAM_DEPTH;  // follows the fixed fill too
		{acq_enable1, acq_enable0} = 2'b00;
		en_fixed_start_addr = 1'b0;
	endtask

	task automatic pop_headers();
		logic [WORD_W-1:0] exp_h;
		int n;
		n = exp_hdr.size();
		for (int i = 0; i < n; i++) begin
			@(negedge clk125);
			check_val({cur_test, " empty before pop"}, 0, fill_header_fifo_empty);
			exp_h = exp_hdr.pop_front();
			check_val({cur_test, " header"}, exp_h, fill_header_fifo_out);
			fill_header_fifo_rd_en = 1'b1;
			@(negedge clk125);
			fill_header_fifo_rd_en = 1'b0;
		end
		@(negedge clk125);
		check_val({cur_test, " empty after pops"}, 1, fill_header_fifo_empty);
	endtask

	task automatic read_range(input int addr, input int cnt);
		int prev;
		prev = rd_done_cnt;
		for (int i = 0; i < cnt; i++)
			exp_q.push_back(exp_mem[(addr + i) % RAM_DEPTH]);
		@(negedge clk125);
		pace_en = 1'b1;                           // random almost_full from here on
		rd_start_addr = ADDR_W'(addr);
		rd_burst_cnt = CNT_W'(cnt);
		enable_reading = 1'b1;
		@(negedge clk125);
		enable_reading = 1'b0;
		wait (rd_done_cnt == prev + 1);
		pace_en = 1'b0;
		repeat (4) @(negedge clk125);             // nothing extra may follow
	endtask

	////////////////////
	// stimulus
	initial begin : stimulus
		reset = 1'b1;
		channel_tag = CHAN_TAG;
		adc_sample = '0;
		{acq_enable1, acq_enable0} = 2'b00;
		acq_trig = 1'b0;
		initial_fill_num_wr = 1'b0;
		initial_fill_num = INIT_NUM;
		num_muon_bursts = CNT_W'(MUON_N);
		num_laser_bursts = CNT_W'(LASER_N);
		num_ped_bursts = CNT_W'(PED_N);
		fixed_start_addr = FIXED_ADDR;
		en_fixed_start_addr = 1'b0;
		fill_header_fifo_rd_en = 1'b0;
		rd_start_addr = '0;
		rd_burst_cnt = '0;
		enable_reading = 1'b0;
		rd_fifo_almost_full = 1'b0;
		repeat (10) @(negedge clk125);
		reset = 1'b0;
		@(negedge clk125);
		check_val("reset fill_num", 0, fill_num);
		check_val("reset header empty", 1, fill_header_fifo_empty);
		check_val("reset acq_done", 0, acq_done);

		cur_test = "none trigger";                // enables 00 start nothing
		check_val({cur_test, " acq_enabled"}, 0, acq_enabled);
		acq_trig = 1'b1;
		@(negedge clk125);
		acq_trig = 1'b0;
		repeat (20) @(negedge clk125);
		check_val({cur_test, " acq_done count"}, 0, done_cnt);
		check_val({cur_test, " header empty"}, 1, fill_header_fifo_empty);
		check_val({cur_test, " fill_num"}, 0, fill_num);

		cur_test = "fill number load";
		initial_fill_num_wr = 1'b1;
		@(negedge clk125);
		initial_fill_num_wr = 1'b0;
		@(negedge clk125);
		check_val({cur_test, " fill_num"}, INIT_NUM, fill_num);
		exp_num = INIT_NUM;

		cur_test = "muon fill";
		run_fill(MUON, 1'b0);
		cur_test = "laser fill";
		run_fill(LASER, 1'b0);
		cur_test = "ped fill";
		run_fill(PED, 1'b0);
		cur_test = "fixed address fill";
		run_fill(MUON, 1'b1);
		cur_test = "fill count";
		check_val({cur_test, " acq_done pulses"}, 4, done_cnt);
		check_val({cur_test, " fill_num"}, INIT_NUM + 4, fill_num);

		cur_test = "header fifo";
		pop_headers();
		cur_test = "continuing readout";          // three fills back to back from 0
		read_range(0, 3 + MUON_N + LASER_N + PED_N);
		cur_test = "fixed readout";
		read_range(int'(FIXED_ADDR), 1 + MUON_N);
		check_val("final acq_done pulses", 4, done_cnt);

		$display("Simulation PASSED");
		$finish;
	end

	initial begin : watchdog
		#((FILL_CYC + READ_CYC) * 8 + 2000);
		fail_stop("timeout: the tests did not finish in the expected time");
	end

endmodule

// ==== build.f ====
chan_pkg.sv
chan_if.sv
fill_decode.sv
acq_sequencer.sv
sync_fifo.sv
burst_ram.sv
burst_store.sv
chan_top.sv
chan_tb_sva.sv
chan_tb.sv
